//--- common/demux_pkg.sv
package demux_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------

  // master ports on the downstream side
  localparam int unsigned NUM_PORTS = 3;
  // enough bits to name every master port
  localparam int unsigned SEL_W     = 2;
  // full AXI id width
  localparam int unsigned ID_W      = 4;
  // low id bits that pick an in-flight counter
  localparam int unsigned LOOK_BITS = 2;
  localparam int unsigned NUM_IDS   = 2 ** LOOK_BITS;
  // counter saturates at all ones, so 3 bursts per tracked id
  localparam int unsigned CNT_W     = 2;
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  // beats in a burst are len + 1
  localparam int unsigned LEN_W     = 4;

  // ----------------------------------------------------------
  // types
  // ----------------------------------------------------------

  typedef logic [SEL_W-1:0]     port_sel_t;
  typedef logic [LOOK_BITS-1:0] look_id_t;

  // read address channel payload
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } ar_chan_t;

  // read data channel payload
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic              last;
  } r_chan_t;

  // upstream to downstream half of a read port
  typedef struct packed {
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } rd_req_t;

  // downstream to upstream half of a read port
  typedef struct packed {
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } rd_resp_t;

endpackage

//--- id_tracker/id_tracker.sv
`timescale 1ns/1ps

module id_tracker import demux_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // lookup of the id waiting at the AR input
  input  look_id_t  lookup_id_i,
  output port_sel_t lookup_sel_o,
  output logic      lookup_busy_o,
  output logic      full_o,
  // accepted AR
  input  logic      push_i,
  input  look_id_t  push_id_i,
  input  port_sel_t push_sel_i,
  // last R beat handed to the slave
  input  logic      pop_i,
  input  look_id_t  pop_id_i
);

  // bursts in flight per tracked id
  logic [CNT_W-1:0] cnt_q [NUM_IDS];
  // port the bursts of that id went to
  port_sel_t        sel_q [NUM_IDS];

  logic [NUM_IDS-1:0] push_en;
  logic [NUM_IDS-1:0] pop_en;
  logic [NUM_IDS-1:0] cnt_full;
  logic [NUM_IDS-1:0] cnt_busy;

  // ----------------------------------------------------------
  // one-hot decode of push and pop
  // ----------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_IDS; i++) begin
      push_en[i]  = push_i && (push_id_i == look_id_t'(i));
      pop_en[i]   = pop_i && (pop_id_i == look_id_t'(i));
      cnt_full[i] = &cnt_q[i];
      cnt_busy[i] = |cnt_q[i];
    end
  end

  // lookup is purely combinational
  assign lookup_sel_o  = sel_q[lookup_id_i];
  assign lookup_busy_o = cnt_busy[lookup_id_i];
  // any full counter stalls all new requests
  assign full_o        = |cnt_full;

  // ----------------------------------------------------------
  // in-flight counters
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        // push and pop together cancel out
        if (push_en[i] && !pop_en[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (pop_en[i] && !push_en[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // remembered target port is only meaningful while busy
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_IDS; i++) begin
      if (push_en[i]) begin
        sel_q[i] <= push_sel_i;
      end
    end
  end

endmodule

//--- source/ar_router.sv
`timescale 1ns/1ps

module ar_router import demux_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // slave side request
  input  ar_chan_t                  slv_ar_i,
  input  port_sel_t                 slv_ar_sel_i,
  input  logic                      slv_ar_valid_i,
  output logic                      slv_ar_ready_o,
  // master side requests
  output ar_chan_t [NUM_PORTS-1:0]  mst_ar_o,
  output logic     [NUM_PORTS-1:0]  mst_ar_valid_o,
  input  logic     [NUM_PORTS-1:0]  mst_ar_ready_i,
  // id tracker lookup and push
  input  port_sel_t                 lookup_sel_i,
  input  logic                      lookup_busy_i,
  input  logic                      track_full_i,
  output logic                      push_o
);

  // once valid was shown downstream it must stay up until the transfer
  logic lock_q;
  logic lock_d;
  // request is being offered to the selected port
  logic ar_valid;
  // ready of the port named by the select
  logic sel_ready;

  // ----------------------------------------------------------
  // selected port ready
  // ----------------------------------------------------------
  always_comb begin
    sel_ready = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (slv_ar_sel_i == port_sel_t'(i)) begin
        sel_ready = mst_ar_ready_i[i];
      end
    end
  end

  // ----------------------------------------------------------
  // accept decision
  // ----------------------------------------------------------
  always_comb begin
    ar_valid       = 1'b0;
    slv_ar_ready_o = 1'b0;
    push_o         = 1'b0;
    lock_d         = lock_q;
    if (lock_q) begin
      // decision already taken, ignore the tracker until the transfer
      ar_valid = 1'b1;
      if (sel_ready) begin
        slv_ar_ready_o = 1'b1;
        push_o         = 1'b1;
        lock_d         = 1'b0;
      end
    end else if (!track_full_i && slv_ar_valid_i &&
                 (!lookup_busy_i || (slv_ar_sel_i == lookup_sel_i))) begin
      // id free, or in flight to the same port, so ordering holds
      ar_valid = 1'b1;
      if (sel_ready) begin
        slv_ar_ready_o = 1'b1;
        push_o         = 1'b1;
      end else begin
        // no ready yet, keep valid up from now on
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // payload goes everywhere, valid only to the chosen port
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      mst_ar_o[i]       = slv_ar_i;
      mst_ar_valid_o[i] = ar_valid && (slv_ar_sel_i == port_sel_t'(i));
    end
  end

endmodule

//--- source/r_arbiter.sv
`timescale 1ns/1ps

module r_arbiter import demux_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // beats from the master ports
  input  r_chan_t [NUM_PORTS-1:0]  mst_r_i,
  input  logic    [NUM_PORTS-1:0]  mst_r_valid_i,
  output logic    [NUM_PORTS-1:0]  mst_r_ready_o,
  // merged beat towards the slave
  output r_chan_t                  slv_r_o,
  output logic                     slv_r_valid_o,
  input  logic                     slv_r_ready_i
);

  // port with highest priority in the next free arbitration
  port_sel_t ptr_q;
  // grant frozen while a beat waits for ready
  logic      lock_q;
  port_sel_t lock_idx_q;

  logic      gnt_found;
  port_sel_t gnt_idx;
  port_sel_t next_ptr;

  // ----------------------------------------------------------
  // grant selection
  // ----------------------------------------------------------
  always_comb begin
    int cand;
    gnt_found = 1'b0;
    gnt_idx   = ptr_q;
    cand      = 0;
    if (lock_q) begin
      gnt_found = 1'b1;
      gnt_idx   = lock_idx_q;
    end else begin
      // scan from the pointer, wrapping around
      for (int k = 0; k < NUM_PORTS; k++) begin
        cand = (int'(ptr_q) + k) % NUM_PORTS;
        if (!gnt_found && mst_r_valid_i[cand]) begin
          gnt_found = 1'b1;
          gnt_idx   = port_sel_t'(cand);
        end
      end
    end
  end

  // ----------------------------------------------------------
  // data mux and ready return
  // ----------------------------------------------------------
  always_comb begin
    slv_r_o       = '0;
    slv_r_valid_o = 1'b0;
    mst_r_ready_o = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (gnt_found && (gnt_idx == port_sel_t'(i))) begin
        slv_r_o          = mst_r_i[i];
        slv_r_valid_o    = mst_r_valid_i[i];
        mst_r_ready_o[i] = slv_r_ready_i;
      end
    end
  end

  // priority moves to the port after the winner
  assign next_ptr = (gnt_idx == port_sel_t'(NUM_PORTS - 1)) ? '0 : gnt_idx + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (slv_r_valid_o) begin
      // stalled beat keeps its grant, a transfer releases it
      lock_q     <= !slv_r_ready_i;
      lock_idx_q <= gnt_idx;
      if (slv_r_ready_i) begin
        ptr_q <= next_ptr;
      end
    end
  end

endmodule

//--- source/read_demux.sv
`timescale 1ns/1ps

module read_demux import demux_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // slave port
  input  rd_req_t                   slv_req_i,
  input  port_sel_t                 slv_ar_sel_i,
  output rd_resp_t                  slv_resp_o,
  // master ports
  output rd_req_t  [NUM_PORTS-1:0]  mst_req_o,
  input  rd_resp_t [NUM_PORTS-1:0]  mst_resp_i
);

  // unpacked master channels
  ar_chan_t [NUM_PORTS-1:0] mst_ar;
  logic     [NUM_PORTS-1:0] mst_ar_valid;
  logic     [NUM_PORTS-1:0] mst_ar_ready;
  r_chan_t  [NUM_PORTS-1:0] mst_r;
  logic     [NUM_PORTS-1:0] mst_r_valid;
  logic     [NUM_PORTS-1:0] mst_r_ready;

  // merged R towards the slave
  r_chan_t   slv_r;
  logic      slv_r_valid;
  logic      slv_ar_ready;

  // tracker hookup
  port_sel_t lookup_sel;
  logic      lookup_busy;
  logic      track_full;
  logic      push;
  logic      pop;

  // ----------------------------------------------------------
  // port struct packing
  // ----------------------------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_ports
    assign mst_req_o[i].ar       = mst_ar[i];
    assign mst_req_o[i].ar_valid = mst_ar_valid[i];
    assign mst_req_o[i].r_ready  = mst_r_ready[i];
    assign mst_ar_ready[i]       = mst_resp_i[i].ar_ready;
    assign mst_r[i]              = mst_resp_i[i].r;
    assign mst_r_valid[i]        = mst_resp_i[i].r_valid;
  end

  assign slv_resp_o.ar_ready = slv_ar_ready;
  assign slv_resp_o.r        = slv_r;
  assign slv_resp_o.r_valid  = slv_r_valid;

  // burst retires when its last beat reaches the slave
  assign pop = slv_r_valid && slv_req_i.r_ready && slv_r.last;

  ar_router u_ar_router (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .slv_ar_i       (slv_req_i.ar),
    .slv_ar_sel_i   (slv_ar_sel_i),
    .slv_ar_valid_i (slv_req_i.ar_valid),
    .slv_ar_ready_o (slv_ar_ready),
    .mst_ar_o       (mst_ar),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .lookup_sel_i   (lookup_sel),
    .lookup_busy_i  (lookup_busy),
    .track_full_i   (track_full),
    .push_o         (push)
  );

  // low id bits select the counter
  id_tracker u_id_tracker (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lookup_id_i   (slv_req_i.ar.id[LOOK_BITS-1:0]),
    .lookup_sel_o  (lookup_sel),
    .lookup_busy_o (lookup_busy),
    .full_o        (track_full),
    .push_i        (push),
    .push_id_i     (slv_req_i.ar.id[LOOK_BITS-1:0]),
    .push_sel_i    (slv_ar_sel_i),
    .pop_i         (pop),
    .pop_id_i      (slv_r.id[LOOK_BITS-1:0])
  );

  r_arbiter u_r_arbiter (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mst_r_i       (mst_r),
    .mst_r_valid_i (mst_r_valid),
    .mst_r_ready_o (mst_r_ready),
    .slv_r_o       (slv_r),
    .slv_r_valid_o (slv_r_valid),
    .slv_r_ready_i (slv_req_i.r_ready)
  );

endmodule

//--- tb/tb_read_demux.sv
`timescale 1ns/1ps

module tb_read_demux import demux_pkg::*; ();

  localparam int          NUM_AR  = 60;
  localparam int          TIMEOUT = 2000;
  localparam logic [31:0] SEED    = 32'hdcb3_3ed0;

  logic                     clk_i;
  logic                     rst_i;
  rd_req_t                  slv_req;
  port_sel_t                slv_ar_sel;
  rd_resp_t                 slv_resp;
  rd_req_t  [NUM_PORTS-1:0] mst_req;
  rd_resp_t [NUM_PORTS-1:0] mst_resp;

  logic [31:0] lfsr_q;
  // handshakes seen before the coming edge
  logic                 ar_hs_s;
  logic                 r_hs_s;
  logic [NUM_PORTS-1:0] ar_hs_m;
  logic [NUM_PORTS-1:0] r_hs_m;
  ar_chan_t             ar_seen [NUM_PORTS];
  // slave beat left waiting for ready at the last sample
  logic                 r_stall;
  r_chan_t              r_held;
  // master models keep bursts waiting per port, beat index and idle gap
  ar_chan_t port_q [NUM_PORTS][$];
  int       beat [NUM_PORTS];
  int       gap [NUM_PORTS];
  // expected beats per full id in AR accept order
  r_chan_t  exp_q [2**ID_W][$];
  logic     ar_pending;
  int       issued;
  int       done_cnt;

  read_demux UUT (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .slv_req_i    (slv_req),
    .slv_ar_sel_i (slv_ar_sel),
    .slv_resp_o   (slv_resp),
    .mst_req_o    (mst_req),
    .mst_resp_i   (mst_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // random source and reference model
  // ----------------------------------------------------------

  // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // port index lands in the top byte, beats walk the address word by word
  function automatic logic [DATA_W-1:0] beat_data(port_sel_t port, logic [ADDR_W-1:0] addr,
                                                  int n);
    return (addr + ADDR_W'(n * 4)) ^ {8'(port) + 8'h11, 24'h00_5a3c};
  endfunction

  function automatic r_chan_t expected_beat(port_sel_t port, ar_chan_t ar, int n);
    r_chan_t b;
    b.id   = ar.id;
    b.data = beat_data(port, ar.addr, n);
    b.last = (n == int'(ar.len));
    return b;
  endfunction

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------
  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_r(input string name, input r_chan_t exp, input r_chan_t act);
    if (exp !== act) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------
  // monitor and scoreboard sampled mid cycle
  // ----------------------------------------------------------
  always @(negedge clk_i) begin
    r_chan_t  exp_beat;
    ar_chan_t ar;
    int       hits;
    int       ar_hits;
    if (rst_i) begin
      ar_hs_s = 1'b0;
      r_hs_s  = 1'b0;
      ar_hs_m = '0;
      r_hs_m  = '0;
      r_stall = 1'b0;
    end else begin
      ar_hs_s = slv_req.ar_valid && slv_resp.ar_ready;
      r_hs_s  = slv_resp.r_valid && slv_req.r_ready;
      hits    = 0;
      ar_hits = 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        ar_hs_m[p] = mst_req[p].ar_valid && mst_resp[p].ar_ready;
        r_hs_m[p]  = mst_resp[p].r_valid && mst_req[p].r_ready;
        ar_seen[p] = mst_req[p].ar;
        if (r_hs_m[p]) begin
          hits++;
        end
        if (ar_hs_m[p]) begin
          ar_hits++;
        end
        // valid never shows on a port that was not selected
        if (!slv_req.ar_valid || slv_ar_sel != port_sel_t'(p)) begin
          check_bit("ar_route", 1'b0, mst_req[p].ar_valid);
        end
      end
      // exactly one master beat per slave beat
      check_bit("r_merge", 1'b1, hits == (r_hs_s ? 1 : 0));
      // a master takes a request only when the slave hands one over
      check_bit("ar_fanout", 1'b1, ar_hits == (ar_hs_s ? 1 : 0));
      // a stalled beat stays on the slave port unchanged
      if (r_stall) begin
        check_bit("r_hold_valid", 1'b1, slv_resp.r_valid);
        check_r("r_hold", r_held, slv_resp.r);
      end
      r_stall = slv_resp.r_valid && !slv_req.r_ready;
      r_held  = slv_resp.r;
      if (ar_hs_s) begin
        ar = slv_req.ar;
        check_bit("ar_accept", 1'b1, ar_hs_m[slv_ar_sel]);
        check_bit("ar_payload", 1'b1, mst_req[slv_ar_sel].ar == ar);
        for (int b = 0; b <= int'(ar.len); b++) begin
          exp_q[ar.id].push_back(expected_beat(slv_ar_sel, ar, b));
        end
      end
      if (r_hs_s) begin
        if (exp_q[slv_resp.r.id].size() == 0) begin
          $display("beat with id %h arrived with no burst outstanding", slv_resp.r.id);
          abort_run();
        end else begin
          exp_beat = exp_q[slv_resp.r.id].pop_front();
          check_r("r_beat", exp_beat, slv_resp.r);
          if (exp_beat.last) begin
            done_cnt++;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------
  // stimulus with one step per cycle
  // ----------------------------------------------------------
  task automatic drive_cycle();
    // master models go first since they use the handshakes of the last edge
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (ar_hs_m[p]) begin
        if (port_q[p].size() == 0) begin
          gap[p] = int'(take_bits(3));
        end
        port_q[p].push_back(ar_seen[p]);
      end
      if (r_hs_m[p]) begin
        mst_resp[p].r_valid = 1'b0;
        if (mst_resp[p].r.last) begin
          void'(port_q[p].pop_front());
          beat[p] = 0;
          gap[p]  = int'(take_bits(3));
        end else begin
          beat[p]++;
        end
      end
      // a shown beat stays until taken
      if (!mst_resp[p].r_valid && port_q[p].size() != 0) begin
        if (gap[p] != 0) begin
          gap[p]--;
        end else begin
          mst_resp[p].r.id    = port_q[p][0].id;
          mst_resp[p].r.data  = beat_data(port_sel_t'(p), port_q[p][0].addr, beat[p]);
          mst_resp[p].r.last  = (beat[p] == int'(port_q[p][0].len));
          mst_resp[p].r_valid = 1'b1;
        end
      end
      mst_resp[p].ar_ready = 1'(take_bits(1));
    end
    // slave AR source
    if (ar_pending && ar_hs_s) begin
      ar_pending = 1'b0;
    end
    if (!ar_pending) begin
      slv_req.ar_valid = 1'b0;
      if (issued < NUM_AR && take_bits(1) == 1) begin
        slv_req.ar.id    = ID_W'(take_bits(ID_W));
        slv_req.ar.addr  = ADDR_W'(take_bits(ADDR_W));
        slv_req.ar.len   = LEN_W'(take_bits(LEN_W));
        slv_ar_sel       = port_sel_t'(take_bits(8) % NUM_PORTS);
        slv_req.ar_valid = 1'b1;
        ar_pending       = 1'b1;
        issued++;
      end
    end
    slv_req.r_ready = (take_bits(2) != 0);
  endtask

  initial begin
    int wait_cyc;
    lfsr_q     = SEED;
    rst_i      = 1'b1;
    slv_req    = '0;
    slv_ar_sel = '0;
    mst_resp   = '0;
    ar_pending = 1'b0;
    issued     = 0;
    done_cnt   = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      beat[p] = 0;
      gap[p]  = 0;
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // idle outputs right after reset
    @(negedge clk_i);
    check_bit("idle_r_valid", 1'b0, slv_resp.r_valid);
    check_bit("idle_ar_ready", 1'b0, slv_resp.ar_ready);
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_bit("idle_mst_ar_valid", 1'b0, mst_req[p].ar_valid);
    end

    // issue all requests and time out on one that is never taken
    wait_cyc = 0;
    while (issued < NUM_AR || ar_pending) begin
      @(posedge clk_i);
      #1;
      drive_cycle();
      if (ar_pending) begin
        wait_cyc++;
      end else begin
        wait_cyc = 0;
      end
      if (wait_cyc > TIMEOUT) begin
        $display("timeout: request %0d was not accepted within %0d cycles", issued, TIMEOUT);
        abort_run();
      end
    end

    // drain the remaining bursts
    wait_cyc = 0;
    while (done_cnt < NUM_AR) begin
      @(posedge clk_i);
      #1;
      drive_cycle();
      wait_cyc++;
      if (wait_cyc > TIMEOUT) begin
        $display("timeout: only %0d of %0d bursts completed", done_cnt, NUM_AR);
        abort_run();
      end
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- filelist.f
common/demux_pkg.sv
id_tracker/id_tracker.sv
source/ar_router.sv
source/r_arbiter.sv
source/read_demux.sv
tb/tb_read_demux.sv

//--- run.sh
#!/bin/sh
rm -f sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_read_demux -f filelist.f \
  -o sim_read_demux > build.log 2>&1 \
  && ./obj_dir/sim_read_demux > sim.log 2>&1
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
